// File: src/pkt_gen_config.svh
`ifndef PKT_GEN_CONFIG_SVH
`define PKT_GEN_CONFIG_SVH

//////////////////////////////////////////////////
// channel and sample geometry
//////////////////////////////////////////////////

// adc channels on the board
`define PG_N_CH 6
// adc sample width, two's complement
`define PG_ADC_W 18
// integral is 48 integer + 16 fraction bits
`define PG_INT_W 64
`define PG_FRAC_W 16

//////////////////////////////////////////////////
// frame layout
//////////////////////////////////////////////////

`define PG_WORD_W 32
// 6 raw + 6 integral + sample counter
`define PG_FRAME_LEN 13
`define PG_IDX_W 4

//////////////////////////////////////////////////
// register port and sync
//////////////////////////////////////////////////

`define PG_REG_OFF_W 16
// bank code sits in offset bits 15..5
`define PG_BANK_LSB 5
`define PG_BANK_ADC_OFF 0
`define PG_BANK_INT_OFF 1
`define PG_SYNC_STAGES 2

`endif

// File: src/pkt_gen_pkg.sv
`include "pkt_gen_config.svh"

package pkt_gen_pkg;

	//////////////////////////////////////////////////
	// scalar types
	//////////////////////////////////////////////////

	// raw adc sample
	typedef logic signed [`PG_ADC_W-1:0] adc_sample_t;

	// 48.16 fixed point integral
	typedef logic signed [`PG_INT_W-1:0] integral_t;

	// one frame word on the output
	typedef logic [`PG_WORD_W-1:0] word_t;

	// position inside the frame, 0..12
	typedef logic [`PG_IDX_W-1:0] word_idx_t;

	//////////////////////////////////////////////////
	// bundles
	//////////////////////////////////////////////////

	// per-channel calibration
	typedef struct packed {
		// electrical offset, subtracted from every sample
		adc_sample_t adc_off;
		// wander offset, 16.16, subtracted from the integral
		word_t int_off;
	} chan_cfg_t;

	// sequencer to integrators and frame mux
	typedef struct packed {
		// stream off, integrals forced to zero
		logic clear;
		// single cycle, integral update
		logic integrate;
		word_idx_t word_idx;
		// high for the whole frame
		logic emit;
	} seq_ctrl_t;

	// register write strobe
	typedef struct packed {
		logic en;
		logic [`PG_REG_OFF_W-1:0] offset;
		word_t data;
	} reg_wr_t;

endpackage

// File: src/calib_regs.sv
`timescale 1ns/100ps
`include "pkt_gen_config.svh"

module calib_regs (
	input logic ff_clk,
	input logic pio_reset_n,
	input pkt_gen_pkg::reg_wr_t reg_wr_i,
	output pkt_gen_pkg::chan_cfg_t cfg_o [`PG_N_CH]
);
	import pkt_gen_pkg::*;

	localparam int BANK_W = `PG_REG_OFF_W - `PG_BANK_LSB;
	localparam int IDX_BITS = `PG_BANK_LSB;

	logic [BANK_W-1:0] wr_bank;
	logic [IDX_BITS-1:0] wr_idx;
	logic hit_adc;
	logic hit_int;
	adc_sample_t [`PG_N_CH-1:0] adc_off_q;
	word_t [`PG_N_CH-1:0] int_off_q;

	//////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////

	// upper offset bits pick the bank, low bits the channel
	assign wr_bank = reg_wr_i.offset[`PG_REG_OFF_W-1:`PG_BANK_LSB];
	assign wr_idx = reg_wr_i.offset[`PG_BANK_LSB-1:0];
	assign hit_adc = reg_wr_i.en && (wr_bank == BANK_W'(`PG_BANK_ADC_OFF));
	assign hit_int = reg_wr_i.en && (wr_bank == BANK_W'(`PG_BANK_INT_OFF));

	// offset banks
	// index 6 and above matches no channel and drops out
	always_ff @(posedge ff_clk or negedge pio_reset_n)
	begin
		if (!pio_reset_n)
		begin
			adc_off_q <= '0;
			int_off_q <= '0;
		end
		else
		begin
			for (int i = 0; i < `PG_N_CH; i++)
			begin
				if (wr_idx == IDX_BITS'(i))
				begin
					// adc bank keeps only the sample width
					if (hit_adc)
						adc_off_q[i] <= reg_wr_i.data[`PG_ADC_W-1:0];
					if (hit_int)
						int_off_q[i] <= reg_wr_i.data;
				end
			end
		end
	end

	// fan out one struct per channel
	always_comb
	begin
		for (int i = 0; i < `PG_N_CH; i++)
		begin
			cfg_o[i].adc_off = adc_off_q[i];
			cfg_o[i].int_off = int_off_q[i];
		end
	end

	// unknown bank code must not touch any offset
	a_unknown_bank_ignored: assert property (@(posedge ff_clk) disable iff (!pio_reset_n)
		(reg_wr_i.en && !hit_adc && !hit_int) |=> ($stable(adc_off_q) && $stable(int_off_q)));

endmodule

// File: src/sample_sequencer.sv
`timescale 1ns/100ps
`include "pkt_gen_config.svh"

module sample_sequencer (
	input logic ff_clk,
	input logic pio_reset_n,
	input logic stream_on_i,
	input logic sync_n_i,
	input logic trigger_n_i,
	output pkt_gen_pkg::seq_ctrl_t seq_o,
	output pkt_gen_pkg::word_t sample_cnt_o
);
	import pkt_gen_pkg::*;

	localparam word_idx_t LAST_IDX = word_idx_t'(`PG_FRAME_LEN - 1);
	// integrals update here before words 6..11 go out
	localparam word_idx_t INT_IDX = word_idx_t'(1);

	logic [`PG_SYNC_STAGES:0] sync_sr;
	logic sync_fall;
	logic emit_q;
	word_idx_t idx_q;
	word_t cnt_q;

	//////////////////////////////////////////////////
	// word sync synchronizer
	//////////////////////////////////////////////////

	// bit 0 is the first stage
	// top bit holds the previous synced value
	// idle level of the strobe is high
	always_ff @(posedge ff_clk or negedge pio_reset_n)
	begin
		if (!pio_reset_n)
			sync_sr <= '1;
		else
			sync_sr <= {sync_sr[`PG_SYNC_STAGES-1:0], sync_n_i};
	end

	// falling edge means high before and low now
	assign sync_fall = sync_sr[`PG_SYNC_STAGES] & ~sync_sr[`PG_SYNC_STAGES-1];

	//////////////////////////////////////////////////
	// frame word index
	//////////////////////////////////////////////////

	always_ff @(posedge ff_clk or negedge pio_reset_n)
	begin
		if (!pio_reset_n)
		begin
			emit_q <= 1'b0;
			idx_q <= '0;
		end
		else if (!stream_on_i)
		begin
			// no frames at all while the stream is off
			emit_q <= 1'b0;
			idx_q <= '0;
		end
		else if (sync_fall)
		begin
			// new sample restarts any frame in flight
			emit_q <= 1'b1;
			idx_q <= '0;
		end
		else if (emit_q)
		begin
			// park on the last word
			if (idx_q == LAST_IDX)
				emit_q <= 1'b0;
			else
				idx_q <= idx_q + word_idx_t'(1);
		end
	end

	// sample counter runs independent of stream_on
	// trigger low restarts numbering at 1
	always_ff @(posedge ff_clk or negedge pio_reset_n)
	begin
		if (!pio_reset_n)
			cnt_q <= '0;
		else if (sync_fall)
			cnt_q <= trigger_n_i ? cnt_q + word_t'(1) : word_t'(1);
	end

	always_comb
	begin
		seq_o.clear = ~stream_on_i;
		seq_o.integrate = emit_q && (idx_q == INT_IDX);
		seq_o.word_idx = idx_q;
		seq_o.emit = emit_q;
	end

	assign sample_cnt_o = cnt_q;

	// integrate follows the first word of a running frame, once
	a_integrate_in_frame: assert property (@(posedge ff_clk) disable iff (!pio_reset_n)
		seq_o.integrate |-> $past(seq_o.emit) && $past(seq_o.word_idx) == word_idx_t'(0)
			##1 !seq_o.integrate);

	// frame never longer than its word count
	a_emit_len: assert property (@(posedge ff_clk) disable iff (!pio_reset_n)
		$rose(seq_o.emit) |-> ##[1:`PG_FRAME_LEN] !seq_o.emit);

endmodule

// File: src/chan_integrator.sv
`timescale 1ns/100ps
`include "pkt_gen_config.svh"

module chan_integrator (
	input logic ff_clk,
	input logic pio_reset_n,
	input pkt_gen_pkg::seq_ctrl_t seq_i,
	input pkt_gen_pkg::chan_cfg_t cfg_i,
	input pkt_gen_pkg::adc_sample_t adc_i,
	input logic chop_i,
	input logic chop_rec_en_i,
	output pkt_gen_pkg::word_t int_word_o
);
	import pkt_gen_pkg::*;

	logic chop_neg;
	adc_sample_t rec;
	integral_t rec_term;
	integral_t wo_term;
	integral_t integ_next;
	integral_t integ_q;

	//////////////////////////////////////////////////
	// sample reconstruction
	//////////////////////////////////////////////////

	// inverted chop phase only matters when reconstruction is on
	assign chop_neg = chop_rec_en_i & chop_i;

	// offset removal, negated in the inverted phase
	// result wraps at the sample width
	always_comb
	begin
		if (chop_neg)
			rec = cfg_i.adc_off - adc_i;
		else
			rec = adc_i - cfg_i.adc_off;
	end

	//////////////////////////////////////////////////
	// accumulation
	//////////////////////////////////////////////////

	// sample lands on the integer part of 48.16
	assign rec_term = integral_t'(rec) <<< `PG_FRAC_W;

	// wander offset is 16.16, sign extended
	assign wo_term = integral_t'($signed(cfg_i.int_off));

	assign integ_next = integ_q + rec_term - wo_term;

	always_ff @(posedge ff_clk or negedge pio_reset_n)
	begin
		if (!pio_reset_n)
			integ_q <= '0;
		else if (seq_i.clear)
			// held at zero while the stream is off
			integ_q <= '0;
		else if (seq_i.integrate)
			integ_q <= integ_next;
	end

	// frame word: integer bits 31..0 of the integral
	assign int_word_o = integ_q[`PG_FRAC_W +: `PG_WORD_W];

endmodule

// File: src/frame_mux.sv
`timescale 1ns/100ps
`include "pkt_gen_config.svh"

module frame_mux (
	input logic ff_clk,
	input logic pio_reset_n,
	input pkt_gen_pkg::seq_ctrl_t seq_i,
	input pkt_gen_pkg::adc_sample_t adc_i [`PG_N_CH],
	input pkt_gen_pkg::word_t int_word_i [`PG_N_CH],
	input pkt_gen_pkg::word_t sample_cnt_i,
	output pkt_gen_pkg::word_t frame_word_o,
	output logic frame_valid_o
);
	import pkt_gen_pkg::*;

	localparam int EXT_W = `PG_WORD_W - `PG_ADC_W;
	localparam int N_BYTES = `PG_WORD_W / 8;

	word_t sel_word;
	word_t swap_word;
	word_t word_q;
	logic valid_q;

	//////////////////////////////////////////////////
	// word select
	//////////////////////////////////////////////////

	// 0..5 raw adc, 6..11 integrals, 12 sample counter
	always_comb
	begin
		sel_word = '0;
		for (int i = 0; i < `PG_N_CH; i++)
		begin
			if (seq_i.word_idx == word_idx_t'(i))
				sel_word = {{EXT_W{adc_i[i][`PG_ADC_W-1]}}, adc_i[i]};
			if (seq_i.word_idx == word_idx_t'(i + `PG_N_CH))
				sel_word = int_word_i[i];
		end
		if (seq_i.word_idx == word_idx_t'(`PG_FRAME_LEN - 1))
			sel_word = sample_cnt_i;
	end

	// byte reversal for the big-endian dma
	always_comb
	begin
		for (int b = 0; b < N_BYTES; b++)
			swap_word[8*b +: 8] = sel_word[`PG_WORD_W-8-8*b +: 8];
	end

	//////////////////////////////////////////////////
	// output stage
	//////////////////////////////////////////////////

	// data word, no reset
	always_ff @(posedge ff_clk)
	begin
		word_q <= swap_word;
	end

	// valid follows emit by one cycle
	always_ff @(posedge ff_clk or negedge pio_reset_n)
	begin
		if (!pio_reset_n)
			valid_q <= 1'b0;
		else
			valid_q <= seq_i.emit;
	end

	assign frame_word_o = word_q;
	assign frame_valid_o = valid_q;

endmodule

// File: src/pkt_gen_top.sv
`timescale 1ns/100ps
`include "pkt_gen_config.svh"

module pkt_gen_top (
	input logic ff_clk,
	input logic pio_reset_n,
	input pkt_gen_pkg::reg_wr_t reg_wr_i,
	input logic stream_on_i,
	input logic sync_n_i,
	input logic trigger_n_i,
	input logic chop_i,
	input logic chop_rec_en_i,
	input pkt_gen_pkg::adc_sample_t adc_i [`PG_N_CH],
	output pkt_gen_pkg::word_t frame_word_o,
	output logic frame_valid_o
);
	import pkt_gen_pkg::*;

	chan_cfg_t cfg [`PG_N_CH];
	seq_ctrl_t seq;
	word_t sample_cnt;
	word_t int_word [`PG_N_CH];

	// offset banks, written from the register port
	calib_regs calib_regs_i (
		.ff_clk (ff_clk),
		.pio_reset_n (pio_reset_n),
		.reg_wr_i (reg_wr_i),
		.cfg_o (cfg)
	);

	// sync edge, frame index and sample counter
	sample_sequencer sample_sequencer_i (
		.ff_clk (ff_clk),
		.pio_reset_n (pio_reset_n),
		.stream_on_i (stream_on_i),
		.sync_n_i (sync_n_i),
		.trigger_n_i (trigger_n_i),
		.seq_o (seq),
		.sample_cnt_o (sample_cnt)
	);

	//////////////////////////////////////////////////
	// one integrator per channel
	//////////////////////////////////////////////////

	for (genvar c = 0; c < `PG_N_CH; c++)
	begin : g_chan
		chan_integrator chan_integrator_i (
			.ff_clk (ff_clk),
			.pio_reset_n (pio_reset_n),
			.seq_i (seq),
			.cfg_i (cfg[c]),
			.adc_i (adc_i[c]),
			.chop_i (chop_i),
			.chop_rec_en_i (chop_rec_en_i),
			.int_word_o (int_word[c])
		);
	end

	// word select, byte swap, output register
	frame_mux frame_mux_i (
		.ff_clk (ff_clk),
		.pio_reset_n (pio_reset_n),
		.seq_i (seq),
		.adc_i (adc_i),
		.int_word_i (int_word),
		.sample_cnt_i (sample_cnt),
		.frame_word_o (frame_word_o),
		.frame_valid_o (frame_valid_o)
	);

endmodule

// File: dv/pkt_gen_checker.sv
`timescale 1ns/100ps
`include "pkt_gen_config.svh"

module pkt_gen_checker (
	input logic ff_clk,
	input logic pio_reset_n,
	input pkt_gen_pkg::reg_wr_t reg_wr_i,
	input logic stream_on_i,
	input logic sync_n_i,
	input logic trigger_n_i,
	input logic chop_i,
	input logic chop_rec_en_i,
	input pkt_gen_pkg::adc_sample_t adc_i [`PG_N_CH],
	input pkt_gen_pkg::word_t frame_word_i,
	input logic frame_valid_i,
	output int err_cnt_o,
	output int word_cnt_o,
	output int frame_cnt_o
);
	import pkt_gen_pkg::*;

	// first word seen 4 cycles after the sync, some slack
	localparam int FRAME_WAIT = 8;

	// model state
	chan_cfg_t [`PG_N_CH-1:0] cfg_m;
	integral_t [`PG_N_CH-1:0] integ_m;
	word_t cnt_m;
	word_t [`PG_FRAME_LEN-1:0] exp_words;
	logic sync_q;
	logic pending;
	logic in_frame;
	int out_idx;
	int cyc;
	int deadline;
	int errs = 0;
	int words = 0;
	int frames = 0;

	always @(posedge ff_clk or negedge pio_reset_n)
	begin
		int bank;
		int idx;
		adc_sample_t [`PG_N_CH-1:0] adc_p;
		integral_t [`PG_N_CH-1:0] integ_n;
		if (!pio_reset_n)
		begin
			cfg_m = '0;
			integ_m = '0;
			cnt_m = '0;
			sync_q = 1'b1;
			pending = 1'b0;
			in_frame = 1'b0;
			out_idx = 0;
			cyc = 0;
			deadline = 0;
		end
		else
		begin
			cyc++;
			//////////////////////////////////////////////////
			// register write mirror
			//////////////////////////////////////////////////
			if (reg_wr_i.en)
			begin
				bank = int'(reg_wr_i.offset[`PG_REG_OFF_W-1:`PG_BANK_LSB]);
				idx = int'(reg_wr_i.offset[`PG_BANK_LSB-1:0]);
				if (idx < `PG_N_CH && bank == `PG_BANK_ADC_OFF)
					cfg_m[idx].adc_off = reg_wr_i.data[`PG_ADC_W-1:0];
				if (idx < `PG_N_CH && bank == `PG_BANK_INT_OFF)
					cfg_m[idx].int_off = reg_wr_i.data;
			end
			// stream off holds the integrals at zero
			if (!stream_on_i)
				integ_m = '0;

			//////////////////////////////////////////////////
			// output side
			//////////////////////////////////////////////////
			if (frame_valid_i)
			begin
				if (!pending)
				begin
					$display("%0t: valid word out of any frame, no sync came before it", $time);
					errs++;
				end
				else
				begin
					if (out_idx < `PG_FRAME_LEN)
					begin
						words++;
						if (frame_word_i !== exp_words[out_idx])
						begin
							$display("ERR %0t: word %0d expected %08h got %08h",
								$time, out_idx, exp_words[out_idx], frame_word_i);
							errs++;
						end
					end
					out_idx++;
					in_frame = 1'b1;
				end
			end
			else if (in_frame)
			begin
				// valid just dropped, frame done
				if (out_idx != `PG_FRAME_LEN)
				begin
					$display("frame ending at %0t had %0d words instead of %0d",
						$time, out_idx, `PG_FRAME_LEN);
					errs++;
				end
				else
					frames++;
				in_frame = 1'b0;
				pending = 1'b0;
				out_idx = 0;
			end
			else if (pending && cyc > deadline)
			begin
				$display("no frame came out after the sync, gave up at %0t", $time);
				errs++;
				pending = 1'b0;
			end

			//////////////////////////////////////////////////
			// sync seen on the input pin
			//////////////////////////////////////////////////
			if (sync_q && !sync_n_i)
			begin
				if (pending && !in_frame)
				begin
					$display("no frame came out before the next sync at %0t", $time);
					errs++;
					pending = 1'b0;
				end
				// counter runs even with the stream off
				cnt_m = trigger_n_i ? cnt_m + word_t'(1) : word_t'(1);
				if (stream_on_i)
				begin
					for (int c = 0; c < `PG_N_CH; c++)
						adc_p[c] = adc_i[c];
					exp_words = tb_pkt_gen.expected_frame(adc_p, cfg_m, chop_i,
						chop_rec_en_i, integ_m, cnt_m, integ_n);
					integ_m = integ_n;
					pending = 1'b1;
					deadline = cyc + FRAME_WAIT;
				end
			end
			sync_q = sync_n_i;
		end
	end

	assign err_cnt_o = errs;
	assign word_cnt_o = words;
	assign frame_cnt_o = frames;

endmodule

// File: dv/tb_pkt_gen.sv
`timescale 1ns/100ps
`include "pkt_gen_config.svh"

module tb_pkt_gen;
	import pkt_gen_pkg::*;

	localparam int CLK_HALF = 50;
	localparam int RESET_CYCLES = 10;
	localparam int SYNC_PERIOD = 20;
	localparam int N_SYNCS = 60;
	// sync periods plus margin for reset and drain
	localparam int TIMEOUT_CYCLES = N_SYNCS * SYNC_PERIOD + 200;

	logic ff_clk;
	logic pio_reset_n;
	reg_wr_t reg_wr_i;
	logic stream_on_i;
	logic sync_n_i;
	logic trigger_n_i;
	logic chop_i;
	logic chop_rec_en_i;
	adc_sample_t adc_i [`PG_N_CH];
	word_t frame_word_o;
	logic frame_valid_o;

	logic [31:0] rnd_state;
	int cycles = 0;
	int frames_expected;
	int err_cnt;
	int word_cnt;
	int frame_cnt;
	int total_err;

	//////////////////////////////////////////////////
	// helpers and reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t next_rand();
		rnd_state = xorshift32(rnd_state);
		return rnd_state;
	endfunction

	// big-endian dma order
	function automatic word_t byte_reverse(input word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// 13 expected words plus the integrals after this sample
	function automatic word_t [`PG_FRAME_LEN-1:0] expected_frame(
		input adc_sample_t [`PG_N_CH-1:0] adc,
		input chan_cfg_t [`PG_N_CH-1:0] cfg,
		input logic chop,
		input logic chop_rec_en,
		input integral_t [`PG_N_CH-1:0] prev,
		input word_t cnt,
		output integral_t [`PG_N_CH-1:0] next
	);
		word_t [`PG_FRAME_LEN-1:0] words;
		adc_sample_t rec;
		integral_t raw;
		integral_t wander;
		for (int c = 0; c < `PG_N_CH; c++)
		begin
			// sample minus offset is flipped in the inverted chop phase
			if (chop_rec_en && chop)
				rec = cfg[c].adc_off - adc[c];
			else
				rec = adc[c] - cfg[c].adc_off;
			// wander offset is 16.16
			wander = integral_t'($signed(cfg[c].int_off));
			next[c] = prev[c] + integral_t'(rec) * integral_t'(65536) - wander;
			raw = integral_t'($signed(adc[c]));
			words[c] = byte_reverse(raw[`PG_WORD_W-1:0]);
			words[c + `PG_N_CH] = byte_reverse(next[c][`PG_FRAC_W +: `PG_WORD_W]);
		end
		words[`PG_FRAME_LEN-1] = byte_reverse(cnt);
		return words;
	endfunction

	// single register write that the caller clears a cycle later
	task automatic drive_write(input int bank, input int idx, input word_t data);
		reg_wr_i.en = 1'b1;
		reg_wr_i.offset = 16'((bank << `PG_BANK_LSB) | idx);
		reg_wr_i.data = data;
	endtask

	// one sync period of 20 cycles
	task automatic run_period(input int n);
		word_t r;
		@(negedge ff_clk);
		r = next_rand();
		sync_n_i = 1'b0;
		// syncs 30..32 with the stream off
		stream_on_i = !(n >= 30 && n < 33);
		chop_rec_en_i = (n >= 20 && n < 30) || n >= 40;
		trigger_n_i = (n % 13) != 7;
		chop_i = r[0];
		for (int c = 0; c < `PG_N_CH; c++)
		begin
			r = next_rand();
			adc_i[c] = r[`PG_ADC_W-1:0];
		end
		if (stream_on_i)
			frames_expected++;
		repeat (2) @(negedge ff_clk);
		sync_n_i = 1'b1;
		repeat (14) @(negedge ff_clk);
		// offsets change for the next sample once the frame is out
		if ((n >= 10 && n < 20) || n >= 40)
		begin
			r = next_rand();
			// index 6 and 7 land nowhere
			drive_write(int'(r[0]), int'(r[3:1]), next_rand());
		end
		@(negedge ff_clk);
		reg_wr_i.en = 1'b0;
		if (n >= 10 && n % 2 == 1)
		begin
			r = next_rand();
			// unused bank codes
			drive_write(r[4] ? 2 : 1024, int'(r[2:0]), next_rand());
		end
		@(negedge ff_clk);
		reg_wr_i.en = 1'b0;
		@(negedge ff_clk);
	endtask

	//////////////////////////////////////////////////
	// clock, dut, checker
	//////////////////////////////////////////////////

	initial
	begin
		ff_clk = 1'b0;
		forever
			#CLK_HALF ff_clk = ~ff_clk;
	end

	pkt_gen_top pkt_gen_top_i (
		.ff_clk (ff_clk),
		.pio_reset_n (pio_reset_n),
		.reg_wr_i (reg_wr_i),
		.stream_on_i (stream_on_i),
		.sync_n_i (sync_n_i),
		.trigger_n_i (trigger_n_i),
		.chop_i (chop_i),
		.chop_rec_en_i (chop_rec_en_i),
		.adc_i (adc_i),
		.frame_word_o (frame_word_o),
		.frame_valid_o (frame_valid_o)
	);

	pkt_gen_checker pkt_gen_checker_i (
		.ff_clk (ff_clk),
		.pio_reset_n (pio_reset_n),
		.reg_wr_i (reg_wr_i),
		.stream_on_i (stream_on_i),
		.sync_n_i (sync_n_i),
		.trigger_n_i (trigger_n_i),
		.chop_i (chop_i),
		.chop_rec_en_i (chop_rec_en_i),
		.adc_i (adc_i),
		.frame_word_i (frame_word_o),
		.frame_valid_i (frame_valid_o),
		.err_cnt_o (err_cnt),
		.word_cnt_o (word_cnt),
		.frame_cnt_o (frame_cnt)
	);

	// run limit
	always @(posedge ff_clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, test did not reach its end", cycles);
			$display("tests failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// stimulus and closing report
	//////////////////////////////////////////////////

	initial
	begin
		rnd_state = 32'he104;
		frames_expected = 0;
		pio_reset_n = 1'b0;
		reg_wr_i = '0;
		stream_on_i = 1'b1;
		sync_n_i = 1'b1;
		trigger_n_i = 1'b1;
		chop_i = 1'b0;
		chop_rec_en_i = 1'b0;
		for (int c = 0; c < `PG_N_CH; c++)
			adc_i[c] = '0;
		repeat (RESET_CYCLES) @(posedge ff_clk);
		@(negedge ff_clk);
		pio_reset_n = 1'b1;
		// no frame may show up in this idle gap
		repeat (5) @(negedge ff_clk);
		for (int n = 0; n < N_SYNCS; n++)
			run_period(n);
		// drain the last frame
		repeat (SYNC_PERIOD) @(negedge ff_clk);
		total_err = err_cnt;
		if (frame_cnt != frames_expected)
		begin
			$display("frame count wrong, %0d frames seen, %0d expected",
				frame_cnt, frames_expected);
			total_err++;
		end
		$display("errors %0d, frames %0d, words checked %0d", total_err, frame_cnt, word_cnt);
		if (total_err == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+src
src/pkt_gen_pkg.sv
src/calib_regs.sv
src/sample_sequencer.sv
src/chan_integrator.sv
src/frame_mux.sv
src/pkt_gen_top.sv
dv/pkt_gen_checker.sv
dv/tb_pkt_gen.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_pkt_gen
RTL_TOP ?= pkt_gen_top
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= all tests passed
RTL_SRCS ?= src/pkt_gen_pkg.sv src/calib_regs.sv src/sample_sequencer.sv \
	src/chan_integrator.sv src/frame_mux.sv src/pkt_gen_top.sv
SRCS := $(wildcard src/*.sv src/*.svh dv/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "simulation PASS"; \
	else echo "simulation FAIL"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Isrc $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
